// ==== source/limb_spi_pkg.sv ====
package limb_spi_pkg;

    // bus widths
    localparam int WORD_W     = 32;
    localparam int HALF_W     = 16;
    localparam int TRIG_W     = 16;
    localparam int HALF_CNT_W = 18;
    localparam int RB_ADDR_W  = 3;

    typedef logic [WORD_W-1:0] word_t;     // one spindle or muscle word
    typedef logic [HALF_W-1:0] half_t;     // host wire word

    // host trigger bits
    localparam int TRIG_HALF_CNT   = 7;    // low wire word only
    localparam int TRIG_MUSCLE_LEN = 8;    // {hi, lo}

    // readback map, 6 and 7 read zero
    localparam logic [RB_ADDR_W-1:0] RB_LEN_LO = 3'd0;
    localparam logic [RB_ADDR_W-1:0] RB_LEN_HI = 3'd1;
    localparam logic [RB_ADDR_W-1:0] RB_TRI_LO = 3'd2;
    localparam logic [RB_ADDR_W-1:0] RB_TRI_HI = 3'd3;
    localparam logic [RB_ADDR_W-1:0] RB_BIC_LO = 3'd4;
    localparam logic [RB_ADDR_W-1:0] RB_BIC_HI = 3'd5;

    // values after reset
    localparam word_t                 LEN_RESET        = '0;
    localparam word_t                 RATE_RESET       = '0;
    localparam logic [HALF_CNT_W-1:0] HALF_CNT_DEFAULT = 18'd400;

endpackage

// ==== source/param_bank.sv ====
`timescale 1ns/1ns

module param_bank #(
    parameter logic [limb_spi_pkg::HALF_CNT_W-1:0] RESET_HALF_CNT =
        limb_spi_pkg::HALF_CNT_DEFAULT
) (
    input  logic                                   ep50trig,
    input  logic                                   reset_global,
    input  logic [limb_spi_pkg::TRIG_W-1:0]        i_trig,
    input  limb_spi_pkg::half_t                    i_wire_lo,
    input  limb_spi_pkg::half_t                    i_wire_hi,
    input  logic [limb_spi_pkg::RB_ADDR_W-1:0]     i_rb_addr,
    input  limb_spi_pkg::word_t                    i_bic_rate,
    input  limb_spi_pkg::word_t                    i_tri_rate,
    output logic [limb_spi_pkg::HALF_CNT_W-1:0]    o_half_cnt,
    output limb_spi_pkg::word_t                    o_muscle_len,
    output limb_spi_pkg::half_t                    o_rb_data
);

    localparam int HW = limb_spi_pkg::HALF_W;
    localparam int WW = limb_spi_pkg::WORD_W;

    logic ld_half_cnt;
    logic ld_muscle_len;

    assign ld_half_cnt   = i_trig[limb_spi_pkg::TRIG_HALF_CNT];
    assign ld_muscle_len = i_trig[limb_spi_pkg::TRIG_MUSCLE_LEN];

    ////////////////////
    // trigger-loaded registers
    ////////////////////

    // tick half-count, zero-extended from the low wire word
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            o_half_cnt <= RESET_HALF_CNT;
        end else if (ld_half_cnt) begin
            o_half_cnt <= limb_spi_pkg::HALF_CNT_W'(i_wire_lo);
        end
    end

    // muscle length sent to both spindle chips
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            o_muscle_len <= limb_spi_pkg::LEN_RESET;
        end else if (ld_muscle_len) begin
            o_muscle_len <= {i_wire_hi, i_wire_lo};
        end
    end

    ////////////////////
    // host readback
    ////////////////////

    always_comb begin
        case (i_rb_addr)
            limb_spi_pkg::RB_LEN_LO: o_rb_data = o_muscle_len[HW-1:0];
            limb_spi_pkg::RB_LEN_HI: o_rb_data = o_muscle_len[WW-1:HW];
            limb_spi_pkg::RB_TRI_LO: o_rb_data = i_tri_rate[HW-1:0];
            limb_spi_pkg::RB_TRI_HI: o_rb_data = i_tri_rate[WW-1:HW];
            limb_spi_pkg::RB_BIC_LO: o_rb_data = i_bic_rate[HW-1:0];
            limb_spi_pkg::RB_BIC_HI: o_rb_data = i_bic_rate[WW-1:HW];
            default:                 o_rb_data = '0;    // unmapped
        endcase
    end

    // a zero half-count can only come from the host writing zero
    a_half_cnt_zero_written: assert property (
        @(posedge ep50trig) disable iff (reset_global)
        (o_half_cnt == '0) |->
            ($past(o_half_cnt) == '0) || $past(ld_half_cnt && (i_wire_lo == '0))
    ) else $error("half-count became zero without a zero write");

endmodule

// ==== source/sim_tick_gen.sv ====
`timescale 1ns/1ns

module sim_tick_gen (
    input  logic                                ep50trig,
    input  logic                                reset_global,
    input  logic [limb_spi_pkg::HALF_CNT_W-1:0] i_half_cnt,
    output logic                                o_sim_tick
);

    logic [limb_spi_pkg::HALF_CNT_W-1:0] cnt;
    logic                                running;    // low only in the first cycle out of reset

    // down-counter, reload picks up a new half-count only at the wrap
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            cnt     <= '0;
            running <= 1'b0;
        end else begin
            running <= 1'b1;
            if (!running || cnt == '0) begin
                cnt <= i_half_cnt;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // one cycle per wrap, period is half-count + 1
    assign o_sim_tick = running && (cnt == '0);

    a_tick_single: assert property (
        @(posedge ep50trig) disable iff (reset_global)
        o_sim_tick |=> !o_sim_tick || ($past(i_half_cnt) == '0)
    ) else $error("sim tick held high with a nonzero half-count");

endmodule

// ==== source/spi_frame_tx.sv ====
`timescale 1ns/1ns

module spi_frame_tx #(
    parameter int CLK_DIV = 13    // half-period minus one
) (
    input  logic                ep50trig,
    input  logic                reset_global,
    input  logic                i_sim_tick,
    input  limb_spi_pkg::word_t i_word,
    output logic                o_sck,
    output logic                o_mosi,
    output logic                o_ssel_n
);

    localparam int WW        = limb_spi_pkg::WORD_W;
    localparam int DIV_W     = (CLK_DIV > 0) ? $clog2(CLK_DIV + 1) : 1;
    localparam int BIT_CNT_W = $clog2(WW + 1);

    localparam logic [DIV_W-1:0]     DIV_LAST = DIV_W'(CLK_DIV);
    localparam logic [BIT_CNT_W-1:0] BIT_LAST = BIT_CNT_W'(WW);

    typedef enum logic {
        ST_IDLE,
        ST_SHIFT
    } state_t;

    state_t              state;
    logic [DIV_W-1:0]     div_cnt;
    logic [BIT_CNT_W-1:0] bit_cnt;    // falling edges so far
    limb_spi_pkg::word_t  shreg;
    logic                 half_done;

    assign half_done = (div_cnt == DIV_LAST);
    assign o_mosi    = shreg[WW-1];    // msb first

    ////////////////////
    // frame FSM
    ////////////////////

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            state    <= ST_IDLE;
            div_cnt  <= '0;
            bit_cnt  <= '0;
            shreg    <= '0;
            o_sck    <= 1'b0;
            o_ssel_n <= 1'b1;
        end else begin
            case (state)
                ST_IDLE: begin
                    // word captured at the tick, ssel drops next cycle
                    if (i_sim_tick) begin
                        state    <= ST_SHIFT;
                        shreg    <= i_word;
                        div_cnt  <= '0;
                        bit_cnt  <= '0;
                        o_ssel_n <= 1'b0;
                    end
                end
                ST_SHIFT: begin
                    // ticks seen here are dropped
                    div_cnt <= half_done ? '0 : div_cnt + 1'b1;
                    if (half_done) begin
                        if (o_sck) begin
                            o_sck   <= 1'b0;
                            shreg   <= {shreg[WW-2:0], 1'b0};    // next bit after fall
                            bit_cnt <= bit_cnt + 1'b1;
                        end else if (bit_cnt != BIT_LAST) begin
                            o_sck <= 1'b1;
                        end else begin
                            // one idle half-period after the last fall
                            o_ssel_n <= 1'b1;
                            state    <= ST_IDLE;
                        end
                    end
                end
            endcase
        end
    end

    a_sck_idle_low: assert property (
        @(posedge ep50trig) disable iff (reset_global)
        o_ssel_n |-> !o_sck
    ) else $error("sck high while ssel is deasserted");

endmodule

// ==== source/spi_frame_rx.sv ====
`timescale 1ns/1ns

module spi_frame_rx (
    input  logic                ep50trig,
    input  logic                reset_global,
    input  logic                i_sim_tick,
    input  logic                i_sck,
    input  logic                i_mosi,
    input  logic                i_ssel_n,
    output limb_spi_pkg::word_t o_rate
);

    localparam int WW        = limb_spi_pkg::WORD_W;
    localparam int BIT_CNT_W = $clog2(WW + 1);

    localparam logic [BIT_CNT_W-1:0] BIT_FULL = BIT_CNT_W'(WW);

    logic [2:0]           sck_sync;     // [1] synchronized, [2] one cycle older
    logic [2:0]           ssel_sync;
    logic [1:0]           mosi_sync;
    logic                 sck_rise;
    logic                 ssel_rise;
    logic                 ssel_low;
    logic [BIT_CNT_W-1:0] bit_cnt;
    logic                 overrun;      // more than a word clocked in
    limb_spi_pkg::word_t  shreg;
    limb_spi_pkg::word_t  pending;

    ////////////////////
    // pin synchronizer
    ////////////////////

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            sck_sync  <= '0;
            ssel_sync <= '1;    // idle high
            mosi_sync <= '0;
        end else begin
            sck_sync  <= {sck_sync[1:0], i_sck};
            ssel_sync <= {ssel_sync[1:0], i_ssel_n};
            mosi_sync <= {mosi_sync[0], i_mosi};
        end
    end

    assign sck_rise  = sck_sync[1] & ~sck_sync[2];
    assign ssel_rise = ssel_sync[1] & ~ssel_sync[2];
    assign ssel_low  = ~ssel_sync[1];

    // data bits, msb arrives first
    always_ff @(posedge ep50trig) begin
        if (ssel_low && sck_rise) begin
            shreg <= {shreg[WW-2:0], mosi_sync[1]};
        end
    end

    ////////////////////
    // frame check and publish
    ////////////////////

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            bit_cnt <= '0;
            overrun <= 1'b0;
            pending <= limb_spi_pkg::RATE_RESET;
            o_rate  <= limb_spi_pkg::RATE_RESET;
        end else begin
            if (ssel_rise) begin
                // keep only an exact 32-bit frame, newest wins
                if (bit_cnt == BIT_FULL && !overrun) begin
                    pending <= shreg;
                end
                bit_cnt <= '0;
                overrun <= 1'b0;
            end else if (ssel_low && sck_rise) begin
                if (bit_cnt == BIT_FULL) begin
                    overrun <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
            if (i_sim_tick) begin
                o_rate <= pending;    // tick closes the latency
            end
        end
    end

    a_bit_cnt_range: assert property (
        @(posedge ep50trig) disable iff (reset_global)
        ssel_low |-> (bit_cnt <= BIT_FULL)
    ) else $error("rx bit counter past a full word");

endmodule

// ==== source/limb_link_top.sv ====
`timescale 1ns/1ns

module limb_link_top #(
    parameter int CLK_DIV = 13,
    parameter logic [limb_spi_pkg::HALF_CNT_W-1:0] RESET_HALF_CNT =
        limb_spi_pkg::HALF_CNT_DEFAULT
) (
    input  logic                               ep50trig,
    input  logic                               reset_global,
    input  logic [limb_spi_pkg::TRIG_W-1:0]    i_trig,
    input  limb_spi_pkg::half_t                i_wire_lo,
    input  limb_spi_pkg::half_t                i_wire_hi,
    input  logic [limb_spi_pkg::RB_ADDR_W-1:0] i_rb_addr,
    input  logic                               i_bic_sck,
    input  logic                               i_bic_mosi,
    input  logic                               i_bic_ssel_n,
    input  logic                               i_tri_sck,
    input  logic                               i_tri_mosi,
    input  logic                               i_tri_ssel_n,
    output limb_spi_pkg::half_t                o_rb_data,
    output logic                               o_bic_sck,
    output logic                               o_bic_mosi,
    output logic                               o_bic_ssel_n,
    output logic                               o_tri_sck,
    output logic                               o_tri_mosi,
    output logic                               o_tri_ssel_n
);

    logic [limb_spi_pkg::HALF_CNT_W-1:0] half_cnt;
    limb_spi_pkg::word_t                 muscle_len;
    limb_spi_pkg::word_t                 bic_rate;
    limb_spi_pkg::word_t                 tri_rate;
    logic                                sim_tick;

    ////////////////////
    // host registers and tick
    ////////////////////

    param_bank #(
        .RESET_HALF_CNT (RESET_HALF_CNT)
    ) param_bank_i (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_trig       (i_trig),
        .i_wire_lo    (i_wire_lo),
        .i_wire_hi    (i_wire_hi),
        .i_rb_addr    (i_rb_addr),
        .i_bic_rate   (bic_rate),
        .i_tri_rate   (tri_rate),
        .o_half_cnt   (half_cnt),
        .o_muscle_len (muscle_len),
        .o_rb_data    (o_rb_data)
    );

    sim_tick_gen sim_tick_gen_i (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_half_cnt   (half_cnt),
        .o_sim_tick   (sim_tick)
    );

    ////////////////////
    // spindle chip links
    ////////////////////

    // same length word goes to both muscles
    spi_frame_tx #(.CLK_DIV(CLK_DIV)) biceps_tx (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_sim_tick   (sim_tick),
        .i_word       (muscle_len),
        .o_sck        (o_bic_sck),
        .o_mosi       (o_bic_mosi),
        .o_ssel_n     (o_bic_ssel_n)
    );

    spi_frame_tx #(.CLK_DIV(CLK_DIV)) triceps_tx (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_sim_tick   (sim_tick),
        .i_word       (muscle_len),
        .o_sck        (o_tri_sck),
        .o_mosi       (o_tri_mosi),
        .o_ssel_n     (o_tri_ssel_n)
    );

    spi_frame_rx biceps_rx (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_sim_tick   (sim_tick),
        .i_sck        (i_bic_sck),
        .i_mosi       (i_bic_mosi),
        .i_ssel_n     (i_bic_ssel_n),
        .o_rate       (bic_rate)
    );

    spi_frame_rx triceps_rx (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_sim_tick   (sim_tick),
        .i_sck        (i_tri_sck),
        .i_mosi       (i_tri_mosi),
        .i_ssel_n     (i_tri_ssel_n),
        .o_rate       (tri_rate)
    );

endmodule

// ==== dv/tb_limb_link.sv ====
`timescale 1ns/1ns

module tb_limb_link;

    localparam int CLK_DIV      = 3;
    localparam int PEER_HALF    = 4;                        // peer sck half-period in cycles
    localparam int TICK_MAX     = 401;                      // reset tick period, the longest used
    localparam int FRAME_CYCLES = 2 * (CLK_DIV + 1) * 33 + 2;
    localparam int PEER_FRAME   = PEER_HALF * 66;
    localparam int TEST_CYCLES  = 32 + (TICK_MAX + FRAME_CYCLES) + 5 * TICK_MAX
                                  + (PEER_FRAME + 2 * TICK_MAX) + (PEER_FRAME + 3 * TICK_MAX);
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    logic                                ep50trig;
    logic                                reset_global;
    logic [limb_spi_pkg::TRIG_W-1:0]     i_trig;
    limb_spi_pkg::half_t                 i_wire_lo;
    limb_spi_pkg::half_t                 i_wire_hi;
    logic [limb_spi_pkg::RB_ADDR_W-1:0]  i_rb_addr;
    logic                                i_bic_sck;
    logic                                i_bic_mosi;
    logic                                i_bic_ssel_n;
    logic                                i_tri_sck;
    logic                                i_tri_mosi;
    logic                                i_tri_ssel_n;
    limb_spi_pkg::half_t                 o_rb_data;
    logic                                o_bic_sck;
    logic                                o_bic_mosi;
    logic                                o_bic_ssel_n;
    logic                                o_tri_sck;
    logic                                o_tri_mosi;
    logic                                o_tri_ssel_n;

    int          errors = 0;
    int          sva_errors = 0;
    int          checks = 0;
    int          cycle_count = 0;
    logic [31:0] lfsr_state = 32'h5343;
    logic        sck_q;
    logic        ssel_q;
    logic [31:0] mon_bits;                                  // biceps frame, msb first
    int          mon_edges;
    int          mon_starts;
    int          mon_frames;
    int          mon_start_cycle;

    limb_link_top #(
        .CLK_DIV        (CLK_DIV),
        .RESET_HALF_CNT (18'd400)
    ) limb_link_top_i (.*);

    initial begin
        ep50trig = 1'b0;
        forever #10 ep50trig = ~ep50trig;
    end

    always @(posedge ep50trig) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: no end of run after %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    ////////////////////
    // biceps frame monitor
    ////////////////////

    always @(posedge ep50trig) begin
        if (reset_global) begin
            sck_q           <= 1'b0;
            ssel_q          <= 1'b1;
            mon_bits        <= '0;
            mon_edges       <= 0;
            mon_starts      <= 0;
            mon_frames      <= 0;
            mon_start_cycle <= 0;
        end else begin
            sck_q  <= o_bic_sck;
            ssel_q <= o_bic_ssel_n;
            if (ssel_q && !o_bic_ssel_n) begin                 // ssel fall
                mon_bits        <= '0;
                mon_edges       <= 0;
                mon_starts      <= mon_starts + 1;
                mon_start_cycle <= cycle_count;
            end else if (!sck_q && o_bic_sck && !o_bic_ssel_n) begin
                mon_bits  <= {mon_bits[30:0], o_bic_mosi};
                mon_edges <= mon_edges + 1;
            end
            if (!ssel_q && o_bic_ssel_n) begin
                mon_frames <= mon_frames + 1;
            end
        end
    end

    // triceps pins track the biceps pins cycle for cycle
    a_channels_match: assert property (
        @(posedge ep50trig) disable iff (reset_global)
        (o_tri_ssel_n == o_bic_ssel_n) && (o_tri_sck == o_bic_sck) && (o_tri_mosi == o_bic_mosi)
    ) else begin
        $display("FAILED at %0t ns: o_tri_ssel_n/sck/mosi = %b%b%b, biceps = %b%b%b", $time,
                 o_tri_ssel_n, o_tri_sck, o_tri_mosi, o_bic_ssel_n, o_bic_sck, o_bic_mosi);
        sva_errors++;
    end

    ////////////////////
    // helpers
    ////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};      // x^32 + x^22 + x^2 + x + 1
    endfunction

    task automatic random_bits(input int n, output logic [31:0] v);
        v = '0;
        repeat (n) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge ep50trig);
        #2;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_readback(input logic [limb_spi_pkg::RB_ADDR_W-1:0] addr,
                                  input logic [15:0] exp);
        i_rb_addr = addr;
        #1;
        check_value($sformatf("o_rb_data at address %0d", addr), 32'(o_rb_data), 32'(exp));
    endtask

    task automatic check_rates(input logic [31:0] bic_w, input logic [31:0] tri_w);
        check_readback(limb_spi_pkg::RB_BIC_LO, bic_w[15:0]);
        check_readback(limb_spi_pkg::RB_BIC_HI, bic_w[31:16]);
        check_readback(limb_spi_pkg::RB_TRI_LO, tri_w[15:0]);
        check_readback(limb_spi_pkg::RB_TRI_HI, tri_w[31:16]);
    endtask

    task automatic pulse_trigger(input int idx, input logic [31:0] w);
        i_trig    = 16'd1 << idx;
        i_wire_hi = w[31:16];
        i_wire_lo = w[15:0];
        wait_cycles(1);
        i_trig = '0;
    endtask

    task automatic wait_frame_start();
        int seen;
        seen = mon_starts;
        while (mon_starts == seen) begin
            wait_cycles(1);
        end
    endtask

    task automatic wait_frame_end();
        int seen;
        seen = mon_frames;
        while (mon_frames == seen) begin
            wait_cycles(1);
        end
    endtask

    // spindle chip side, both receivers clocked together, top nbits sent
    task automatic send_rx_frames(input logic [31:0] bic_w, input logic [31:0] tri_w,
                                  input int nbits);
        logic [31:0] b;
        logic [31:0] t;
        b = bic_w;
        t = tri_w;
        i_bic_ssel_n = 1'b0;
        i_tri_ssel_n = 1'b0;
        repeat (nbits) begin
            i_bic_mosi = b[31];
            i_tri_mosi = t[31];
            b = b << 1;
            t = t << 1;
            wait_cycles(PEER_HALF);
            i_bic_sck = 1'b1;
            i_tri_sck = 1'b1;
            wait_cycles(PEER_HALF);
            i_bic_sck = 1'b0;
            i_tri_sck = 1'b0;
        end
        wait_cycles(PEER_HALF);
        i_bic_ssel_n = 1'b1;
        i_tri_ssel_n = 1'b1;
        wait_cycles(PEER_HALF);
    endtask

    ////////////////////
    // test sequence
    ////////////////////

    initial begin
        int          a;
        int          e0;
        int          t1;
        logic [31:0] len_w;
        logic [31:0] bic_w;
        logic [31:0] tri_w;
        logic [31:0] half_w;

        reset_global = 1'b1;
        i_trig       = '0;
        i_wire_lo    = '0;
        i_wire_hi    = '0;
        i_rb_addr    = '0;
        i_bic_sck    = 1'b0;
        i_bic_mosi   = 1'b0;
        i_bic_ssel_n = 1'b1;
        i_tri_sck    = 1'b0;
        i_tri_mosi   = 1'b0;
        i_tri_ssel_n = 1'b1;
        wait_cycles(4);
        reset_global = 1'b0;
        wait_cycles(1);

        e0 = errors + sva_errors;
        check_value("o_bic_ssel_n", 32'(o_bic_ssel_n), 32'd1);
        check_value("o_tri_ssel_n", 32'(o_tri_ssel_n), 32'd1);
        check_value("o_bic_sck", 32'(o_bic_sck), 32'd0);
        check_value("o_tri_sck", 32'(o_tri_sck), 32'd0);
        for (a = 0; a < 6; a++) begin
            check_readback(3'(a), 16'h0000);
        end
        $display("test 1 reset state: %0d errors", errors + sva_errors - e0);

        e0 = errors + sva_errors;
        random_bits(32, len_w);
        pulse_trigger(limb_spi_pkg::TRIG_MUSCLE_LEN, len_w);
        check_readback(limb_spi_pkg::RB_LEN_LO, len_w[15:0]);
        check_readback(limb_spi_pkg::RB_LEN_HI, len_w[31:16]);
        pulse_trigger(15, ~len_w);                          // unmapped trigger bit
        check_readback(limb_spi_pkg::RB_LEN_LO, len_w[15:0]);
        check_readback(limb_spi_pkg::RB_LEN_HI, len_w[31:16]);
        $display("test 2 muscle length write: %0d errors", errors + sva_errors - e0);

        e0 = errors + sva_errors;
        wait_frame_start();
        wait_frame_end();
        check_value("o_bic_sck rising edges", mon_edges, 32);
        check_value("o_bic_mosi frame", mon_bits, len_w);
        $display("test 3 transmit frame: %0d errors", errors + sva_errors - e0);

        e0 = errors + sva_errors;
        random_bits(5, half_w);
        half_w = half_w + 32'd280;                          // still longer than one frame
        pulse_trigger(limb_spi_pkg::TRIG_HALF_CNT, {16'hffff, half_w[15:0]});
        wait_frame_start();                                 // wrap that loads the new count
        wait_frame_start();
        repeat (2) begin
            t1 = mon_start_cycle;
            wait_frame_start();
            check_value("o_bic_ssel_n fall interval", mon_start_cycle - t1, half_w + 32'd1);
        end
        $display("test 4 tick period: %0d errors", errors + sva_errors - e0);

        e0 = errors + sva_errors;
        random_bits(32, bic_w);
        random_bits(32, tri_w);
        if (tri_w == bic_w) begin
            tri_w = ~tri_w;
        end
        send_rx_frames(bic_w, tri_w, 32);
        wait_cycles(4);                                     // synchronizer and pending load
        wait_frame_start();
        check_rates(bic_w, tri_w);
        $display("test 5 receive path: %0d errors", errors + sva_errors - e0);

        e0 = errors + sva_errors;
        random_bits(32, len_w);
        send_rx_frames(len_w, ~len_w, 20);
        wait_cycles(4);
        repeat (2) begin
            wait_frame_start();
            check_rates(bic_w, tri_w);
        end
        $display("test 6 short frame: %0d errors", errors + sva_errors - e0);

        $display("tests 6, checks %0d, errors %0d", checks, errors + sva_errors);
        if (errors + sva_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
source/limb_spi_pkg.sv
source/param_bank.sv
source/sim_tick_gen.sv
source/spi_frame_tx.sv
source/spi_frame_rx.sv
source/limb_link_top.sv
dv/tb_limb_link.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the limb link testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_limb_link -f list.f
./obj_dir/Vtb_limb_link > sim.log 2>&1
cat sim.log
if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
